/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs one simulation.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module inst_display_tb \
	-f verilog.f

./obj_dir/Vinst_display_tb > sim.log 2>&1
cat sim.log

if grep -q "All tests passed" sim.log
then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see sim.log"
exit 1

/* sim/inst_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_display_tb
	import vga_timing_pkg::*, isa_text_pkg::*;
;

	localparam int N_ENTRIES = 6;
	localparam int HS_LOW_FIRST = 656; // first pixel of the hs pulse.
	localparam int HS_LOW_END = 752;   // hs is high again here.
	localparam int FIRST_VS_LINE = 490;
	localparam int FRAME_CYCLES = 800 * 525;
	// first vs edge after reset plus seven scanned frames.
	localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES;

	logic    iVGA_CLK;
	logic    iRST_n;
	logic    inst_valid;
	opcode_t opcode;
	regnum_t rs;
	regnum_t rt;
	regnum_t rd;
	regnum_t shamt;
	imm_t    immediate;
	color_t  r_data;
	color_t  g_data;
	color_t  b_data;
	logic    hs;
	logic    vs;

	opcode_t tbl_op [N_ENTRIES];
	regnum_t tbl_rs [N_ENTRIES];
	regnum_t tbl_rt [N_ENTRIES];
	regnum_t tbl_rd [N_ENTRIES];
	regnum_t tbl_shamt [N_ENTRIES];
	imm_t    tbl_imm [N_ENTRIES];
	string   tbl_text [N_ENTRIES];

	integer seed;
	int     errors;
	int     cycle_cnt;

	tb_clock_gen u_clk (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n)
	);

	inst_display_top dut (
		.iVGA_CLK   (iVGA_CLK),
		.iRST_n     (iRST_n),
		.inst_valid (inst_valid),
		.opcode     (opcode),
		.rs         (rs),
		.rt         (rt),
		.rd         (rd),
		.shamt      (shamt),
		.immediate  (immediate),
		.r_data     (r_data),
		.g_data     (g_data),
		.b_data     (b_data),
		.hs         (hs),
		.vs         (vs)
	);

	// ##################################################
	// compare tasks.
	// ##################################################
	task automatic check_color(input string name, input color_t got, input color_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_sync(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input hcount_t got, input hcount_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic set_entry(input int idx, input opcode_t op, input regnum_t s,
		input regnum_t t, input regnum_t d, input regnum_t sh, input imm_t imm,
		input string text);
		tbl_op[idx]    = op;
		tbl_rs[idx]    = s;
		tbl_rt[idx]    = t;
		tbl_rd[idx]    = d;
		tbl_shamt[idx] = sh;
		tbl_imm[idx]   = imm;
		tbl_text[idx]  = text;
	endtask

	// msb of the character code is the leftmost pixel of its cell.
	function automatic logic text_pixel_lit(input string text, input int x);
		char_t code;
		code = char_t'(text[x / 8]);
		return code[7 - (x % 8)];
	endfunction

	task automatic wait_vs_fall();
		do @(negedge iVGA_CLK); while (vs !== 1'b1);
		do @(negedge iVGA_CLK); while (vs !== 1'b0);
	endtask

	// one strobe and then 20 cycles of noise while the burst runs.
	task automatic send_inst(input int idx);
		@(posedge iVGA_CLK);
		#1;
		inst_valid = 1'b1;
		opcode     = tbl_op[idx];
		rs         = tbl_rs[idx];
		rt         = tbl_rt[idx];
		rd         = tbl_rd[idx];
		shamt      = tbl_shamt[idx];
		immediate  = tbl_imm[idx];
		for (int n = 0; n < TEXT_LEN; n++)
		begin
			@(posedge iVGA_CLK);
			#1;
			inst_valid = (n == TEXT_LEN - 1) ? 1'b1 : 1'($random(seed)); // last burst cycle.
			opcode     = tbl_op[(idx + 1) % N_ENTRIES];
			rs         = regnum_t'($random(seed));
			rt         = regnum_t'($random(seed));
			rd         = regnum_t'($random(seed));
			immediate  = imm_t'($random(seed));
		end
		@(posedge iVGA_CLK);
		#1;
		inst_valid = 1'b0;
	endtask

	// ##################################################
	// frame scanner from one vs fall to the next.
	// ##################################################
	task automatic scan_frame(input string text);
		int     hpos;
		int     vline;
		int     low_len;
		int     lines;
		int     vs_lines;
		logic   hs_prev;
		logic   vs_prev;
		logic   hs_exp;
		logic   vs_exp;
		logic   lit;
		color_t rg_exp;
		color_t b_exp;
		bit     done;
		hpos     = 0;
		vline    = FIRST_VS_LINE;
		low_len  = 0;
		lines    = 0;
		vs_lines = 0;
		hs_prev  = hs;
		vs_prev  = vs;
		done     = 1'b0;
		while (!done)
		begin
			hs_exp = !(hpos >= HS_LOW_FIRST && hpos < HS_LOW_END);
			vs_exp = !((vline == 490 && hpos >= 0) || vline == 491 || (vline == 492 && hpos < 0));
			rg_exp = '0;
			b_exp  = '0;
			if (vline >= 0 && vline < 16 && hpos >= 0 && hpos < 160)
			begin
				lit    = text_pixel_lit(text, hpos);
				rg_exp = lit ? 4'd15 : 4'd0;
				b_exp  = lit ? 4'd15 : 4'd4;
			end
			check_sync("hs", hs, hs_exp);
			check_sync("vs", vs, vs_exp);
			check_color("r_data", r_data, rg_exp);
			check_color("g_data", g_data, rg_exp);
			check_color("b_data", b_data, b_exp);
			if (!hs)
				low_len++;
			@(negedge iVGA_CLK);
			if (hs && !hs_prev)
			begin
				check_count("hs low width", hcount_t'(low_len), hcount_t'(96));
				check_count("line length", hcount_t'(hpos + 49), hcount_t'(800));
				low_len = 0;
				lines++;
				if (!vs)
					vs_lines++;
				hpos = -48; // back porch before x = 0.
				vline++;
			end
			else
				hpos++;
			if (vs && !vs_prev)
				vline = -33; // start of vertical back porch.
			if (!vs && vs_prev)
				done = 1'b1;
			hs_prev = hs;
			vs_prev = vs;
		end
		check_count("lines per frame", hcount_t'(lines), hcount_t'(525));
		check_count("vs low lines", hcount_t'(vs_lines), hcount_t'(2));
	endtask

	// ##################################################
	// main sequence.
	// ##################################################
	initial
	begin
		seed       = 32'h6f9c;
		errors     = 0;
		inst_valid = 1'b0;
		opcode     = '0;
		rs         = '0;
		rt         = '0;
		rd         = '0;
		shamt      = '0;
		immediate  = '0;
		set_entry(0, ADD, 5'd1, 5'd2, 5'd3, 5'd0, 16'd0, "add x03 x01 x02     ");
		set_entry(1, SLL, 5'd0, 5'd12, 5'd7, 5'd31, 16'd0, "sll x07 x12 31      ");
		set_entry(2, ADDI, 5'd29, 5'd5, 5'd0, 5'd0, 16'hFF9C, "addi x05 x29 -00100 ");
		set_entry(3, ORI, 5'd0, 5'd10, 5'd0, 5'd0, 16'hFFFF, "ori x10 x00 65535   ");
		set_entry(4, LW, 5'd30, 5'd8, 5'd0, 5'd0, 16'd16, "lw x08 +00016 x30   ");
		set_entry(5, {6'h3E, 6'h01}, 5'd4, 5'd5, 5'd6, 5'd7, 16'd9, "????                ");
		@(posedge iRST_n);
		wait_vs_fall();
		scan_frame("                    "); // blank line left by reset.
		for (int i = 0; i < N_ENTRIES; i++)
		begin
			// the burst ends in line 490 long before the text rows.
			fork
				send_inst(i);
				scan_frame(tbl_text[i]);
			join
		end
		$display("%0d errors", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge iVGA_CLK);
			cycle_cnt++;
		end
		$display("timeout: the frames did not complete within %0d cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic iVGA_CLK,
	output logic iRST_n
);

	// 10 ns period, 100 MHz stands in for the pixel clock.
	initial
	begin
		iVGA_CLK = 1'b0;
		forever #5 iVGA_CLK = ~iVGA_CLK;
	end

	initial
	begin
		iRST_n = 1'b0;
		repeat (3) @(posedge iVGA_CLK);
		#1 iRST_n = 1'b1; // released with the same offset as other inputs.
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/vga_timing_pkg.sv
verilog/isa_text_pkg.sv
verilog/inst_disasm.sv
verilog/text_line_buffer.sv
verilog/vga_text_raster.sv
verilog/inst_display_top.sv
sim/tb_clock_gen.sv
sim/inst_display_tb.sv

/* verilog/inst_disasm.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_disasm
	import isa_text_pkg::*;
(
	input  wire               iVGA_CLK,
	input  wire               iRST_n,
	input  wire               inst_valid,
	input  wire opcode_t      opcode,
	input  wire regnum_t      rs,
	input  wire regnum_t      rt,
	input  wire regnum_t      rd,
	input  wire regnum_t      shamt,
	input  wire imm_t         immediate,
	output logic              wr_en,
	output text_addr_t        wr_addr,
	output char_t             wr_char
);

	typedef enum logic {IDLE, WRITE} state_t;

	state_t     state;
	text_addr_t idx;   // character being written.
	logic       take;

	opcode_t op_q;
	regnum_t rs_q;
	regnum_t rt_q;
	regnum_t rd_q;
	regnum_t shamt_q;
	imm_t    imm_q;

	char_t [0:MNEM_LEN-1] mnem;
	logic [2:0]           mnem_len;
	char_t [0:OPS_LEN-1]  ops;   // operands, each led by a space.
	char_t                line [TEXT_LEN];
	logic [4:0]           ops_idx;

	// ##################################################
	// decimal text helpers.
	// ##################################################
	function automatic logic [15:0] dec2(input regnum_t v);
		char_t tens;
		char_t ones;
		tens = CHAR_ZERO + char_t'(v / 5'd10);
		ones = CHAR_ZERO + char_t'(v % 5'd10);
		return {tens, ones};
	endfunction

	function automatic logic [39:0] dec5(input imm_t v);
		logic [39:0] txt;
		imm_t        rest;
		rest = v;
		for (int i = 0; i < 5; i++)
		begin
			txt[i*8 +: 8] = CHAR_ZERO + char_t'(rest % 16'd10); // ones digit lands rightmost.
			rest = rest / 16'd10;
		end
		return txt;
	endfunction

	function automatic logic [31:0] reg_txt(input regnum_t v);
		return {" x", dec2(v)};
	endfunction

	function automatic logic [55:0] simm_txt(input imm_t v);
		imm_t mag;
		mag = v[15] ? (~v + 16'd1) : v; // -32768 still fits as a magnitude.
		return {CHAR_SPACE, (v[15] ? CHAR_MINUS : CHAR_PLUS), dec5(mag)};
	endfunction

	function automatic logic [47:0] uimm_txt(input imm_t v);
		return {CHAR_SPACE, dec5(v)};
	endfunction

	// ##################################################
	// control.
	// ##################################################
	assign take = (state == IDLE) && inst_valid; // strobes during a burst are dropped.

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			state <= IDLE;
			idx   <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					idx <= '0;
					if (take)
						state <= WRITE;
				end
				WRITE:
				begin
					idx <= idx + 5'd1;
					if (idx == text_addr_t'(TEXT_LEN - 1))
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge iVGA_CLK)
	begin
		if (take)
		begin
			op_q    <= opcode;
			rs_q    <= rs;
			rt_q    <= rt;
			rd_q    <= rd;
			shamt_q <= shamt;
			imm_q   <= immediate;
		end
	end

	// formatter.
	always_comb
	begin
		mnem     = "????";
		mnem_len = 3'd4;
		ops      = {OPS_LEN{CHAR_SPACE}};
		case (op_q)
			ADD, ADDU, SUB, SUBU, AND_OP, OR_OP, XOR_OP, NOR_OP, SLT:
				ops = {reg_txt(rd_q), reg_txt(rs_q), reg_txt(rt_q), {4{CHAR_SPACE}}};
			SLL, SRL:
				ops = {reg_txt(rd_q), reg_txt(rt_q), CHAR_SPACE, dec2(shamt_q), {5{CHAR_SPACE}}};
			JR:
				ops = {reg_txt(rs_q), {12{CHAR_SPACE}}};
			ADDI, SLTI:
				ops = {reg_txt(rt_q), reg_txt(rs_q), simm_txt(imm_q), CHAR_SPACE};
			ANDI, ORI, XORI:
				ops = {reg_txt(rt_q), reg_txt(rs_q), uimm_txt(imm_q), {2{CHAR_SPACE}}};
			LW, SW:
				ops = {reg_txt(rt_q), simm_txt(imm_q), reg_txt(rs_q), CHAR_SPACE};
			BEQ, BNE:
				ops = {reg_txt(rs_q), reg_txt(rt_q), simm_txt(imm_q), CHAR_SPACE};
			default: ;
		endcase
		case (op_q)
			ADD:     begin mnem = {"add", CHAR_SPACE}; mnem_len = 3'd3; end
			ADDU:    begin mnem = "addu"; mnem_len = 3'd4; end
			SUB:     begin mnem = {"sub", CHAR_SPACE}; mnem_len = 3'd3; end
			SUBU:    begin mnem = "subu"; mnem_len = 3'd4; end
			AND_OP:  begin mnem = {"and", CHAR_SPACE}; mnem_len = 3'd3; end
			OR_OP:   begin mnem = {"or", {2{CHAR_SPACE}}}; mnem_len = 3'd2; end
			XOR_OP:  begin mnem = {"xor", CHAR_SPACE}; mnem_len = 3'd3; end
			NOR_OP:  begin mnem = {"nor", CHAR_SPACE}; mnem_len = 3'd3; end
			SLL:     begin mnem = {"sll", CHAR_SPACE}; mnem_len = 3'd3; end
			SRL:     begin mnem = {"srl", CHAR_SPACE}; mnem_len = 3'd3; end
			SLT:     begin mnem = {"slt", CHAR_SPACE}; mnem_len = 3'd3; end
			JR:      begin mnem = {"jr", {2{CHAR_SPACE}}}; mnem_len = 3'd2; end
			ADDI:    begin mnem = "addi"; mnem_len = 3'd4; end
			ANDI:    begin mnem = "andi"; mnem_len = 3'd4; end
			ORI:     begin mnem = {"ori", CHAR_SPACE}; mnem_len = 3'd3; end
			XORI:    begin mnem = "xori"; mnem_len = 3'd4; end
			LW:      begin mnem = {"lw", {2{CHAR_SPACE}}}; mnem_len = 3'd2; end
			SW:      begin mnem = {"sw", {2{CHAR_SPACE}}}; mnem_len = 3'd2; end
			SLTI:    begin mnem = "slti"; mnem_len = 3'd4; end
			BEQ:     begin mnem = {"beq", CHAR_SPACE}; mnem_len = 3'd3; end
			BNE:     begin mnem = {"bne", CHAR_SPACE}; mnem_len = 3'd3; end
			HLT:     begin mnem = {"hlt", CHAR_SPACE}; mnem_len = 3'd3; end
			default: ;
		endcase
	end

	// operands follow the mnemonic directly, the rest is padding.
	always_comb
	begin
		ops_idx = '0;
		for (int i = 0; i < TEXT_LEN; i++)
		begin
			ops_idx = 5'(i) - 5'(mnem_len);
			if (i < int'(mnem_len))
				line[i] = mnem[2'(i)];
			else if (ops_idx < 5'(OPS_LEN))
				line[i] = ops[ops_idx[3:0]];
			else
				line[i] = CHAR_SPACE;
		end
	end

	assign wr_en   = (state == WRITE);
	assign wr_addr = idx;
	assign wr_char = line[idx];

	a_wr_addr_range: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		wr_en |-> (wr_addr < text_addr_t'(TEXT_LEN)))
		else $error("write index past end of text line");

endmodule

`default_nettype wire

/* verilog/inst_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_display_top
	import vga_timing_pkg::*, isa_text_pkg::*;
(
	input  wire          iVGA_CLK,
	input  wire          iRST_n,
	input  wire          inst_valid,
	input  wire opcode_t opcode,
	input  wire regnum_t rs,
	input  wire regnum_t rt,
	input  wire regnum_t rd,
	input  wire regnum_t shamt,
	input  wire imm_t    immediate,
	output wire color_t  r_data,
	output wire color_t  g_data,
	output wire color_t  b_data,
	output wire          hs,
	output wire          vs
);

	wire             wr_en;
	wire text_addr_t wr_addr;
	wire char_t      wr_char;
	wire text_addr_t rd_addr;
	wire char_t      rd_char;

	inst_disasm u_disasm (
		.iVGA_CLK   (iVGA_CLK),
		.iRST_n     (iRST_n),
		.inst_valid (inst_valid),
		.opcode     (opcode),
		.rs         (rs),
		.rt         (rt),
		.rd         (rd),
		.shamt      (shamt),
		.immediate  (immediate),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_char    (wr_char)
	);

	text_line_buffer u_buffer (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_char  (wr_char),
		.rd_addr  (rd_addr),
		.rd_char  (rd_char)
	);

	vga_text_raster u_raster (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n),
		.rd_char  (rd_char),
		.rd_addr  (rd_addr),
		.r_data   (r_data),
		.g_data   (g_data),
		.b_data   (b_data),
		.hs       (hs),
		.vs       (vs)
	);

endmodule

`default_nettype wire

/* verilog/isa_text_pkg.sv */
`default_nettype none

package isa_text_pkg;

	// {major opcode, function}; function is zero for I-type.
	typedef logic [11:0] opcode_t;
	typedef logic [4:0]  regnum_t;
	typedef logic [15:0] imm_t;
	typedef logic [7:0]  char_t;
	typedef logic [4:0]  text_addr_t;

	localparam int TEXT_LEN = 20; // characters in the line.
	localparam int MNEM_LEN = 4;  // widest mnemonic.
	localparam int OPS_LEN  = 16; // widest operand field.

	localparam char_t CHAR_SPACE = 8'd32;
	localparam char_t CHAR_PLUS  = 8'd43;
	localparam char_t CHAR_MINUS = 8'd45;
	localparam char_t CHAR_ZERO  = 8'd48;

	// ##################################################
	// R-type, major opcode 0.
	// ##################################################
	localparam opcode_t ADD    = {6'h00, 6'h20};
	localparam opcode_t ADDU   = {6'h00, 6'h21};
	localparam opcode_t SUB    = {6'h00, 6'h22};
	localparam opcode_t SUBU   = {6'h00, 6'h23};
	localparam opcode_t AND_OP = {6'h00, 6'h24};
	localparam opcode_t OR_OP  = {6'h00, 6'h25};
	localparam opcode_t XOR_OP = {6'h00, 6'h26};
	localparam opcode_t NOR_OP = {6'h00, 6'h27};
	localparam opcode_t SLL    = {6'h00, 6'h00};
	localparam opcode_t SRL    = {6'h00, 6'h02};
	localparam opcode_t SLT    = {6'h00, 6'h2A};
	localparam opcode_t JR     = {6'h00, 6'h08};

	// ##################################################
	// I-type, function field zero.
	// ##################################################
	localparam opcode_t ADDI = {6'h08, 6'h00};
	localparam opcode_t ANDI = {6'h0C, 6'h00};
	localparam opcode_t ORI  = {6'h0D, 6'h00};
	localparam opcode_t XORI = {6'h0E, 6'h00};
	localparam opcode_t LW   = {6'h23, 6'h00};
	localparam opcode_t SW   = {6'h2B, 6'h00};
	localparam opcode_t SLTI = {6'h0A, 6'h00};
	localparam opcode_t BEQ  = {6'h04, 6'h00};
	localparam opcode_t BNE  = {6'h05, 6'h00};

	localparam opcode_t HLT  = {6'h3F, 6'h00}; // stops the core.

endpackage

`default_nettype wire

/* verilog/text_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module text_line_buffer
	import isa_text_pkg::*;
(
	input  wire             iVGA_CLK,
	input  wire             iRST_n,
	input  wire             wr_en,
	input  wire text_addr_t wr_addr,
	input  wire char_t      wr_char,
	input  wire text_addr_t rd_addr,
	output char_t           rd_char
);

	char_t mem [TEXT_LEN];

	// write port, cleared to a blank line.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			for (int i = 0; i < TEXT_LEN; i++)
				mem[i] <= CHAR_SPACE;
		end
		else if (wr_en && (wr_addr < text_addr_t'(TEXT_LEN)))
		begin
			mem[wr_addr] <= wr_char;
		end
	end

	// registered read, one cycle behind rd_addr.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
			rd_char <= CHAR_SPACE;
		else
			rd_char <= mem[rd_addr];
	end

	a_rd_addr_range: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		rd_addr < text_addr_t'(TEXT_LEN))
		else $error("raster read past end of text line");

endmodule

`default_nettype wire

/* verilog/vga_text_raster.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_text_raster
	import vga_timing_pkg::*, isa_text_pkg::*;
(
	input  wire        iVGA_CLK,
	input  wire        iRST_n,
	input  wire char_t rd_char,
	output text_addr_t rd_addr,
	output color_t     r_data,
	output color_t     g_data,
	output color_t     b_data,
	output logic       hs,
	output logic       vs
);

	hcount_t h_cnt;
	vcount_t v_cnt;

	logic       hs_c;
	logic       vs_c;
	logic       vis_c;
	logic       text_c;
	logic       in_cols; // horizontally inside the text columns.
	logic [2:0] bit_c;

	logic       hs_d1;
	logic       vs_d1;
	logic       vis_d1;
	logic       text_d1;
	logic [2:0] bit_d1;
	logic       pix_on;

	// ##################################################
	// counters.
	// ##################################################
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_cnt == H_TOTAL - 10'd1)
		begin
			h_cnt <= '0;
			if (v_cnt == V_TOTAL - 10'd1)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 10'd1;
		end
		else
		begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	assign hs_c    = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END)); // active low.
	assign vs_c    = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
	assign vis_c   = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
	assign in_cols = h_cnt < hcount_t'(TEXT_LEN * CELL_W);
	assign text_c  = in_cols && (v_cnt < CELL_H);

	// msb of the code is the leftmost pixel of the cell.
	assign bit_c   = 3'(CELL_W - 10'd1 - (h_cnt % CELL_W));

	assign rd_addr = in_cols ? text_addr_t'(h_cnt / CELL_W) : '0;

	// ##################################################
	// stage 1 waits for rd_char.
	// ##################################################
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			hs_d1   <= 1'b1;
			vs_d1   <= 1'b1;
			vis_d1  <= 1'b0;
			text_d1 <= 1'b0;
		end
		else
		begin
			hs_d1   <= hs_c;
			vs_d1   <= vs_c;
			vis_d1  <= vis_c;
			text_d1 <= text_c;
		end
	end

	always_ff @(posedge iVGA_CLK)
	begin
		bit_d1 <= bit_c;
	end

	assign pix_on = rd_char[bit_d1];

	// stage 2 lets colour and sync leave together.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			hs     <= 1'b1;
			vs     <= 1'b1;
			r_data <= '0;
			g_data <= '0;
			b_data <= '0;
		end
		else
		begin
			hs <= hs_d1;
			vs <= vs_d1;
			if (vis_d1 && text_d1)
			begin
				r_data <= pix_on ? FG_LEVEL : '0;
				g_data <= pix_on ? FG_LEVEL : '0;
				b_data <= pix_on ? FG_LEVEL : BG_BLUE; // dark blue behind the text.
			end
			else
			begin
				r_data <= '0; // blanking and the rest of the screen.
				g_data <= '0;
				b_data <= '0;
			end
		end
	end

	// sync at the pins belongs to the same position as the colour.
	a_hs_blank: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		!hs |-> ((r_data == '0) && (g_data == '0) && (b_data == '0)))
		else $error("hsync low during a visible pixel");

endmodule

`default_nettype wire

/* verilog/vga_timing_pkg.sv */
`default_nettype none

package vga_timing_pkg;

	typedef logic [9:0] hcount_t; // pixel position in a line.
	typedef logic [9:0] vcount_t; // line position in a frame.

	localparam int COLORW = 4;

	typedef logic [COLORW-1:0] color_t;

	// ##################################################
	// 640x480 at 60 Hz raster.
	// ##################################################
	localparam hcount_t H_VISIBLE = 10'd640;
	localparam hcount_t H_FRONT   = 10'd16;
	localparam hcount_t H_SYNC    = 10'd96;
	localparam hcount_t H_BACK    = 10'd48;
	localparam hcount_t H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

	localparam vcount_t V_VISIBLE = 10'd480;
	localparam vcount_t V_FRONT   = 10'd10;
	localparam vcount_t V_SYNC    = 10'd2;
	localparam vcount_t V_BACK    = 10'd33;
	localparam vcount_t V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	localparam hcount_t H_SYNC_START = H_VISIBLE + H_FRONT; // 656.
	localparam hcount_t H_SYNC_END   = H_SYNC_START + H_SYNC; // first count after the pulse.
	localparam vcount_t V_SYNC_START = V_VISIBLE + V_FRONT;
	localparam vcount_t V_SYNC_END   = V_SYNC_START + V_SYNC;

	// character cell.
	localparam hcount_t CELL_W = 10'd8;
	localparam vcount_t CELL_H = 10'd16;

	localparam color_t FG_LEVEL = 4'd15; // lit bit, all channels.
	localparam color_t BG_BLUE  = 4'd4;  // unlit bit inside the text area.

endpackage

`default_nettype wire
